/* sources.f */
issue_pkg.sv
decode_issue_unit.sv
alu_pipe.sv
mul_pipe.sv
complete_arbiter.sv
issue_top.sv
issue_properties.sv
issue_checker.sv
issue_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode/issue testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module issue_tb -f sources.f -o issue_sim

./obj_dir/issue_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "Simulation ended without a final status"
  exit 1
fi

/* issue_tb.sv */
// Testbench top for the decode/issue stage. Drives directed and random
// ADD/ADDI/MUL streams into issue_top; issue_checker does the comparing.
`timescale 1ns/1ps

module issue_tb;

  localparam int RDY_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int NUM_RANDOM    = 200;

  logic                 clk;
  logic                 rst;
  logic                 inst_val;
  logic                 inst_rdy;
  issue_pkg::word_t     inst;
  issue_pkg::word_t     pc;
  logic                 complete_val;
  issue_pkg::seq_num_t  complete_seq;
  issue_pkg::reg_addr_t complete_waddr;
  logic                 complete_wen;
  issue_pkg::word_t     complete_wdata;

  int   tb_errors;
  logic timed_out;

  issue_top dut (
    .clk, .rst, .inst_val, .inst_rdy, .inst, .pc,
    .complete_val, .complete_seq, .complete_waddr, .complete_wen, .complete_wdata
  );

  issue_checker chk (
    .clk, .rst, .inst_val, .inst_rdy, .inst,
    .complete_val, .complete_seq, .complete_waddr, .complete_wen, .complete_wdata
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // RV32 encoders
  // --------------------------------------------------------------------------

  function automatic issue_pkg::word_t enc_add(input int rd, input int rs1, input int rs2);
    return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), issue_pkg::OPC_OP};
  endfunction

  function automatic issue_pkg::word_t enc_mul(input int rd, input int rs1, input int rs2);
    return {issue_pkg::FUNCT7_MUL, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), issue_pkg::OPC_OP};
  endfunction

  function automatic issue_pkg::word_t enc_addi(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), issue_pkg::OPC_OP_IMM};
  endfunction

  // --------------------------------------------------------------------------
  // Drivers, all entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------------

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test(input string name);
    chk.set_test(name);
    $display("Running test %s", name);
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    if (timed_out) return;
    while (!inst_rdy && cycles < RDY_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!inst_rdy) begin
      $display("Timeout: inst_rdy never went high after reset");
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Hold val until the edge that sees rdy high
  task automatic send_inst(input issue_pkg::word_t ins);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    if (timed_out) return;
    inst_val = 1'b1;
    inst     = ins;
    pc       = pc + 4;
    while (!done && cycles < RDY_TIMEOUT) begin
      @(negedge clk);
      done = inst_rdy;
      @(posedge clk);
      #1;
      cycles++;
    end
    inst_val = 1'b0;
    if (!done) begin
      $display("Timeout: instruction 0x%08h was never accepted by decode", ins);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    if (timed_out) return;
    while (chk.outstanding != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (chk.outstanding != 0) begin
      $display("Timeout: %0d instructions still outstanding", chk.outstanding);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin : stimulus
    int               op;
    int               imm;
    int               missing;
    int               total;
    issue_pkg::word_t ins;
    void'($urandom(66));
    rst       = 1'b1;
    inst_val  = 1'b0;
    inst      = '0;
    pc        = '0;
    tb_errors = 0;
    timed_out = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Nothing sent, bus stays idle
    start_test("reset_idle");
    wait_ready();
    idle(5);

    // RAW chain through the scoreboard
    start_test("raw_chain");
    send_inst(enc_addi(1, 0, 5));
    send_inst(enc_addi(2, 1, 7));
    send_inst(enc_add(3, 1, 2));
    send_inst(enc_add(4, 3, 3));
    send_inst(enc_addi(1, 4, -3));
    wait_drain();

    // ADD overtakes the MUL
    start_test("mul_then_add");
    send_inst(enc_addi(5, 0, 13));
    send_inst(enc_addi(6, 0, -7));
    wait_drain();
    send_inst(enc_mul(7, 5, 6));
    send_inst(enc_add(8, 5, 5));
    wait_drain();

    // RAW behind a MUL, then a pure WAW on x9, then read it back
    start_test("mul_raw_waw");
    send_inst(enc_mul(9, 5, 5));
    send_inst(enc_add(10, 9, 5));
    send_inst(enc_mul(9, 10, 6));
    // Fast ADDI must not land before the slow MUL to x9
    send_inst(enc_addi(9, 5, 1));
    wait_drain();
    send_inst(enc_addi(11, 9, 0));
    wait_drain();

    // Both x0 writes land before x0 is read
    start_test("x0_writes");
    send_inst(enc_addi(0, 5, 99));
    send_inst(enc_mul(0, 5, 6));
    wait_drain();
    send_inst(enc_add(12, 0, 0));
    send_inst(enc_addi(13, 0, 0));
    wait_drain();

    // Small register range keeps hazards frequent
    start_test("random");
    for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
      op  = $urandom_range(0, 2);
      imm = int'($urandom_range(0, 4095)) - 2048;
      case (op)
        0:       ins = enc_add($urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7));
        1:       ins = enc_addi($urandom_range(0, 7), $urandom_range(0, 7), imm);
        default: ins = enc_mul($urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7));
      endcase
      send_inst(ins);
      idle($urandom_range(0, 3));
    end
    wait_drain();

    missing = chk.count_missing();
    total   = chk.err_count + dut.u_props.fail_count + tb_errors + missing;
    $display("Errors: checker %0d, assertions %0d, testbench %0d, missing %0d",
             chk.err_count, dut.u_props.fail_count, tb_errors, missing);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* issue_checker.sv */
// Scoreboard-style checker for the decode/issue stage. Watches the fetch
// handshake and the completion bus, predicts each result with a model
// register file in program order and compares by sequence tag.
`timescale 1ns/1ps

module issue_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inst_val,
  input  logic                 inst_rdy,
  input  issue_pkg::word_t     inst,
  input  logic                 complete_val,
  input  issue_pkg::seq_num_t  complete_seq,
  input  issue_pkg::reg_addr_t complete_waddr,
  input  logic                 complete_wen,
  input  issue_pkg::word_t     complete_wdata
);

  // Architectural state as seen in program order
  issue_pkg::word_t     model [32];

  // Expected results, one slot per sequence tag
  issue_pkg::reg_addr_t exp_waddr [32];
  logic                 exp_wen   [32];
  issue_pkg::word_t     exp_data  [32];
  string                exp_test  [32];
  logic                 pending   [32];

  issue_pkg::seq_num_t  acc_cnt;
  int                   outstanding = 0;
  int                   err_count   = 0;
  string                test_name   = "reset";

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // Result of one instruction given its two source values
  function automatic issue_pkg::word_t ref_result(input issue_pkg::word_t ins,
                                                  input issue_pkg::word_t a,
                                                  input issue_pkg::word_t b);
    issue_pkg::word_t imm;
    imm = {{20{ins[31]}}, ins[31:20]};
    if (ins[6:0] == issue_pkg::OPC_OP_IMM) begin
      return a + imm;
    end else if (ins[31:25] == issue_pkg::FUNCT7_MUL) begin
      // Low half of the product only
      return a * b;
    end
    return a + b;
  endfunction

  task automatic set_test(input string name);
    test_name = name;
  endtask

  // Lists every tag still waiting, returns how many
  function automatic int count_missing();
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
      if (pending[i]) begin
        $display("Instruction with sequence tag %0d from test %s never completed",
                 i, exp_test[i]);
        n++;
      end
    end
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // Monitor
  // --------------------------------------------------------------------------

  // Negedge view equals what the next rising edge acts on
  always @(negedge clk) begin : watch
    issue_pkg::reg_addr_t rs1;
    issue_pkg::reg_addr_t rs2;
    issue_pkg::reg_addr_t rd;
    issue_pkg::seq_num_t  s;
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        model[i]   = '0;
        pending[i] = 1'b0;
      end
      acc_cnt     = '0;
      outstanding = 0;
    end else begin
      if (complete_val) begin
        s = complete_seq;
        if (!pending[s]) begin
          $display("Completion with sequence tag %0d arrived with nothing outstanding", s);
          err_count++;
        end else begin
          if (complete_waddr != exp_waddr[s]) begin
            $display("** Error [%s] seq %0d waddr: expected %0d, actual %0d",
                     exp_test[s], s, exp_waddr[s], complete_waddr);
            err_count++;
          end
          if (complete_wen != exp_wen[s]) begin
            $display("** Error [%s] seq %0d wen: expected %0b, actual %0b",
                     exp_test[s], s, exp_wen[s], complete_wen);
            err_count++;
          end
          if (complete_wdata != exp_data[s]) begin
            $display("** Error [%s] seq %0d wdata: expected 0x%08h, actual 0x%08h",
                     exp_test[s], s, exp_data[s], complete_wdata);
            err_count++;
          end
          pending[s] = 1'b0;
          outstanding--;
        end
      end
      if (inst_val && inst_rdy) begin
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        rd  = inst[11:7];
        s   = acc_cnt;
        if (pending[s]) begin
          $display("Sequence tag %0d reused while still outstanding", s);
          err_count++;
        end
        exp_data[s]  = ref_result(inst, model[rs1], model[rs2]);
        exp_waddr[s] = rd;
        exp_wen[s]   = (rd != '0);
        exp_test[s]  = test_name;
        pending[s]   = 1'b1;
        // x0 stays zero
        if (rd != '0) begin
          model[rd] = exp_data[s];
        end
        acc_cnt = acc_cnt + issue_pkg::seq_num_t'(1);
        outstanding++;
      end
    end
  end

endmodule

/* issue_properties.sv */
// Concurrent assertions on the decode/issue stage, bound into issue_top.
// Looks at the pipe handshakes, the arbiter grant and the completion bus.
`timescale 1ns/1ps

module issue_properties (
  input logic                                clk,
  input logic                                rst,
  input logic [issue_pkg::NUM_PIPES-1:0]     req,
  input logic [issue_pkg::NUM_PIPES-1:0]     gnt,
  input logic                                alu_val,
  input logic                                mul_val,
  input logic                                complete_val,
  input issue_pkg::seq_num_t                 alu_seq,
  input issue_pkg::reg_addr_t                alu_waddr,
  input logic                                alu_wen,
  input issue_pkg::word_t                    alu_data,
  input issue_pkg::seq_num_t                 mul_seq,
  input issue_pkg::reg_addr_t                mul_waddr,
  input logic                                mul_wen,
  input issue_pkg::word_t                    mul_data
);

  // Failures seen so far, summed into the final error count
  int fail_count = 0;

  // At most one winner per cycle
  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
    else begin $error("Arbiter granted more than one pipe"); fail_count++; end

  // Bus quiet once reset has been seen for a full cycle
  a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !complete_val)
    else begin $error("complete_val high during reset"); fail_count++; end

  // Decode steers to one pipe only
  a_one_issue: assert property (@(posedge clk) disable iff (rst) !(alu_val && mul_val))
    else begin $error("alu_val and mul_val high together"); fail_count++; end

  // --------------------------------------------------------------------------
  // Held requests keep their fields
  // --------------------------------------------------------------------------

  a_alu_hold: assert property (@(posedge clk) disable iff (rst)
      req[issue_pkg::PIPE_ALU] && !gnt[issue_pkg::PIPE_ALU] |=>
      req[issue_pkg::PIPE_ALU] && $stable({alu_seq, alu_waddr, alu_wen, alu_data}))
    else begin $error("ALU request dropped or changed before grant"); fail_count++; end

  a_mul_hold: assert property (@(posedge clk) disable iff (rst)
      req[issue_pkg::PIPE_MUL] && !gnt[issue_pkg::PIPE_MUL] |=>
      req[issue_pkg::PIPE_MUL] && $stable({mul_seq, mul_waddr, mul_wen, mul_data}))
    else begin $error("MUL request dropped or changed before grant"); fail_count++; end

endmodule

bind issue_top issue_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .req          (req),
  .gnt          (gnt),
  .alu_val      (alu_val),
  .mul_val      (mul_val),
  .complete_val (complete_val),
  .alu_seq      (res_seq[issue_pkg::PIPE_ALU]),
  .alu_waddr    (res_waddr[issue_pkg::PIPE_ALU]),
  .alu_wen      (res_wen[issue_pkg::PIPE_ALU]),
  .alu_data     (res_data[issue_pkg::PIPE_ALU]),
  .mul_seq      (res_seq[issue_pkg::PIPE_MUL]),
  .mul_waddr    (res_waddr[issue_pkg::PIPE_MUL]),
  .mul_wen      (res_wen[issue_pkg::PIPE_MUL]),
  .mul_data     (res_data[issue_pkg::PIPE_MUL])
);

/* issue_top.sv */
// Decode/issue stage top level. Fetch handshake in, completion bus out;
// decode feeds the ALU and MUL pipes, which share the bus via the arbiter.
`timescale 1ns/1ps

module issue_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inst_val,
  output logic                 inst_rdy,
  input  issue_pkg::word_t     inst,
  input  issue_pkg::word_t     pc,
  output logic                 complete_val,
  output issue_pkg::seq_num_t  complete_seq,
  output issue_pkg::reg_addr_t complete_waddr,
  output logic                 complete_wen,
  output issue_pkg::word_t     complete_wdata
);

  // Decode to pipes
  logic                 alu_val;
  logic                 alu_rdy;
  logic                 mul_val;
  logic                 mul_rdy;
  issue_pkg::word_t     iss_op1;
  issue_pkg::word_t     iss_op2;
  issue_pkg::reg_addr_t iss_waddr;
  logic                 iss_wen;
  issue_pkg::seq_num_t  iss_seq;
  issue_pkg::uop_t      iss_uop;

  // Pipes to arbiter
  logic [issue_pkg::NUM_PIPES-1:0] req;
  logic [issue_pkg::NUM_PIPES-1:0] gnt;
  logic [issue_pkg::NUM_PIPES-1:0] res_wen;
  issue_pkg::seq_num_t             res_seq   [issue_pkg::NUM_PIPES];
  issue_pkg::reg_addr_t            res_waddr [issue_pkg::NUM_PIPES];
  issue_pkg::word_t                res_data  [issue_pkg::NUM_PIPES];

  decode_issue_unit u_decode (
    .clk, .rst,
    .inst_val, .inst_rdy, .inst, .pc,
    .alu_val, .alu_rdy, .mul_val, .mul_rdy,
    .iss_op1, .iss_op2, .iss_waddr, .iss_wen, .iss_seq, .iss_uop,
    .complete_val, .complete_seq, .complete_waddr, .complete_wen, .complete_wdata
  );

  alu_pipe u_alu (
    .clk, .rst,
    .in_val    (alu_val),
    .in_rdy    (alu_rdy),
    .op1       (iss_op1),
    .op2       (iss_op2),
    .uop       (iss_uop),
    .waddr     (iss_waddr),
    .wen       (iss_wen),
    .seq       (iss_seq),
    .req       (req[issue_pkg::PIPE_ALU]),
    .gnt       (gnt[issue_pkg::PIPE_ALU]),
    .res_seq   (res_seq[issue_pkg::PIPE_ALU]),
    .res_waddr (res_waddr[issue_pkg::PIPE_ALU]),
    .res_wen   (res_wen[issue_pkg::PIPE_ALU]),
    .res_data  (res_data[issue_pkg::PIPE_ALU])
  );

  mul_pipe u_mul (
    .clk, .rst,
    .in_val    (mul_val),
    .in_rdy    (mul_rdy),
    .op1       (iss_op1),
    .op2       (iss_op2),
    .waddr     (iss_waddr),
    .wen       (iss_wen),
    .seq       (iss_seq),
    .req       (req[issue_pkg::PIPE_MUL]),
    .gnt       (gnt[issue_pkg::PIPE_MUL]),
    .res_seq   (res_seq[issue_pkg::PIPE_MUL]),
    .res_waddr (res_waddr[issue_pkg::PIPE_MUL]),
    .res_wen   (res_wen[issue_pkg::PIPE_MUL]),
    .res_data  (res_data[issue_pkg::PIPE_MUL])
  );

  complete_arbiter u_arb (
    .clk, .rst,
    .req, .seq (res_seq), .waddr (res_waddr), .wen (res_wen), .data (res_data),
    .gnt,
    .complete_val, .complete_seq, .complete_waddr, .complete_wen, .complete_wdata
  );

endmodule

/* complete_arbiter.sv */
// Round-robin arbiter for the shared completion bus. Grants one pipe per
// cycle, combinationally, and muxes that pipe's result onto the bus.
`timescale 1ns/1ps

module complete_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  // Pipe requests, indexed by PIPE_ALU / PIPE_MUL
  input  logic [issue_pkg::NUM_PIPES-1:0] req,
  input  issue_pkg::seq_num_t            seq   [issue_pkg::NUM_PIPES],
  input  issue_pkg::reg_addr_t           waddr [issue_pkg::NUM_PIPES],
  input  logic [issue_pkg::NUM_PIPES-1:0] wen,
  input  issue_pkg::word_t               data  [issue_pkg::NUM_PIPES],
  output logic [issue_pkg::NUM_PIPES-1:0] gnt,
  // Completion bus
  output logic                           complete_val,
  output issue_pkg::seq_num_t            complete_seq,
  output issue_pkg::reg_addr_t           complete_waddr,
  output logic                           complete_wen,
  output issue_pkg::word_t               complete_wdata
);

  // One-hot copy of the last grant, zero after reset
  logic [issue_pkg::NUM_PIPES-1:0] last_gnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_gnt <= '0;
    end else if (|gnt) begin
      last_gnt <= gnt;
    end
  end

  // Search starts just past the last winner so it loses ties
  always_comb begin
    int   last_idx;
    int   idx;
    int   win;
    logic found;
    last_idx = 0;
    win      = 0;
    found    = 1'b0;
    gnt      = '0;
    for (int i = 0; i < issue_pkg::NUM_PIPES; i++) begin
      if (last_gnt[i]) begin
        last_idx = i;
      end
    end
    for (int k = 1; k <= issue_pkg::NUM_PIPES; k++) begin
      idx = (last_idx + k) % issue_pkg::NUM_PIPES;
      if (!found && req[idx]) begin
        gnt[idx] = 1'b1;
        win      = idx;
        found    = 1'b1;
      end
    end
    complete_val   = found;
    complete_seq   = seq[win];
    complete_waddr = waddr[win];
    complete_wen   = wen[win];
    complete_wdata = data[win];
  end

endmodule

/* mul_pipe.sv */
// Three-stage multiply pipe, low 32 bits of the product. Partial products
// in stage one, their sum in stage two, result held in the last stage.
// The whole pipe freezes while the last stage waits for a grant.
`timescale 1ns/1ps

module mul_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  issue_pkg::word_t     op1,
  input  issue_pkg::word_t     op2,
  input  issue_pkg::reg_addr_t waddr,
  input  logic                 wen,
  input  issue_pkg::seq_num_t  seq,
  // Completion request
  output logic                 req,
  input  logic                 gnt,
  output issue_pkg::seq_num_t  res_seq,
  output issue_pkg::reg_addr_t res_waddr,
  output logic                 res_wen,
  output issue_pkg::word_t     res_data
);

  localparam int LAST = issue_pkg::MUL_STAGES - 1;

  // Per-stage valid and tag fields
  logic [issue_pkg::MUL_STAGES-1:0] st_val;
  logic [issue_pkg::MUL_STAGES-1:0] st_wen;
  issue_pkg::seq_num_t              st_seq   [issue_pkg::MUL_STAGES];
  issue_pkg::reg_addr_t             st_waddr [issue_pkg::MUL_STAGES];

  // Stage one partial products, later stages the product
  issue_pkg::word_t pp_lo;
  issue_pkg::word_t pp_hi;
  issue_pkg::word_t st_prod [1:LAST];

  logic advance;

  // Lost grant on the last stage stalls everything
  assign advance = !(st_val[LAST] && !gnt);
  assign in_rdy  = advance;

  // --------------------------------------------------------------------------
  // Valid bits
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      st_val <= '0;
    end else if (advance) begin
      st_val <= {st_val[LAST-1:0], in_val};
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (advance) begin
      st_seq[0]   <= seq;
      st_waddr[0] <= waddr;
      st_wen[0]   <= wen;
      // Split op2 in half words, upper product only needs its low half
      pp_lo       <= op1 * {16'b0, op2[15:0]};
      pp_hi       <= op1 * {16'b0, op2[31:16]};
      st_prod[1]  <= pp_lo + {pp_hi[15:0], 16'b0};
      for (int i = 1; i < issue_pkg::MUL_STAGES; i++) begin
        st_seq[i]   <= st_seq[i-1];
        st_waddr[i] <= st_waddr[i-1];
        st_wen[i]   <= st_wen[i-1];
      end
      for (int i = 2; i < issue_pkg::MUL_STAGES; i++) begin
        st_prod[i] <= st_prod[i-1];
      end
    end
  end

  assign req       = st_val[LAST];
  assign res_seq   = st_seq[LAST];
  assign res_waddr = st_waddr[LAST];
  assign res_wen   = st_wen[LAST];
  assign res_data  = st_prod[LAST];

endmodule

/* alu_pipe.sv */
// Single-cycle adder pipe. The sum sits in one result register and
// requests the completion bus until the arbiter grants it.
`timescale 1ns/1ps

module alu_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  issue_pkg::word_t     op1,
  input  issue_pkg::word_t     op2,
  input  issue_pkg::uop_t      uop,
  input  issue_pkg::reg_addr_t waddr,
  input  logic                 wen,
  input  issue_pkg::seq_num_t  seq,
  // Completion request
  output logic                 req,
  input  logic                 gnt,
  output issue_pkg::seq_num_t  res_seq,
  output issue_pkg::reg_addr_t res_waddr,
  output logic                 res_wen,
  output issue_pkg::word_t     res_data
);

  logic             full;
  issue_pkg::word_t sum;

  // ADDI already carries its immediate in op2
  always_comb begin
    case (uop)
      issue_pkg::UOP_ADD,
      issue_pkg::UOP_ADDI: sum = op1 + op2;
      default:             sum = '0;
    endcase
  end

  // Refill in the same cycle as the grant
  assign in_rdy = !full || gnt;
  assign req    = full;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_val && in_rdy) begin
      full <= 1'b1;
    end else if (gnt) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      res_data  <= sum;
      res_seq   <= seq;
      res_waddr <= waddr;
      res_wen   <= wen;
    end
  end

endmodule

/* decode_issue_unit.sv */
// Decode and issue for ADD, ADDI and MUL. Holds one instruction in D,
// reads operands, stalls on scoreboard hazards, tags each issue with a
// sequence number and steers it to the ALU or MUL pipe.
`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch side
  input  logic                 inst_val,
  output logic                 inst_rdy,
  input  issue_pkg::word_t     inst,
  input  issue_pkg::word_t     pc,
  // Pipe handshakes
  output logic                 alu_val,
  input  logic                 alu_rdy,
  output logic                 mul_val,
  input  logic                 mul_rdy,
  // Issue fields shared by both pipes
  output issue_pkg::word_t     iss_op1,
  output issue_pkg::word_t     iss_op2,
  output issue_pkg::reg_addr_t iss_waddr,
  output logic                 iss_wen,
  output issue_pkg::seq_num_t  iss_seq,
  output issue_pkg::uop_t      iss_uop,
  // Completion bus
  input  logic                 complete_val,
  input  issue_pkg::seq_num_t  complete_seq,
  input  issue_pkg::reg_addr_t complete_waddr,
  input  logic                 complete_wen,
  input  issue_pkg::word_t     complete_wdata
);

  // --------------------------------------------------------------------------
  // D register
  // --------------------------------------------------------------------------

  logic                 d_val;
  issue_pkg::word_t     d_inst;
  logic                 issue_fire;

  // Empty, or draining this cycle
  assign inst_rdy = !d_val || issue_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_val <= 1'b0;
    end else if (inst_rdy) begin
      d_val <= inst_val;
    end
  end

  // Payload only, loaded on a fetch transfer
  always_ff @(posedge clk) begin
    if (inst_val && inst_rdy) begin
      d_inst <= inst;
    end
  end

  // --------------------------------------------------------------------------
  // Field decode
  // --------------------------------------------------------------------------

  logic [6:0]           opcode;
  logic [6:0]           funct7;
  issue_pkg::reg_addr_t rs1;
  issue_pkg::reg_addr_t rs2;
  issue_pkg::reg_addr_t rd;
  issue_pkg::word_t     imm_i;
  issue_pkg::uop_t      uop;
  logic                 uses_rs2;
  logic                 rd_wen;

  assign opcode = d_inst[6:0];
  assign rd     = d_inst[11:7];
  assign rs1    = d_inst[19:15];
  assign rs2    = d_inst[24:20];
  assign funct7 = d_inst[31:25];
  // I-type immediate, sign extended
  assign imm_i  = {{20{d_inst[31]}}, d_inst[31:20]};

  // Only three instructions arrive, so OP splits on funct7 alone
  always_comb begin
    if (opcode == issue_pkg::OPC_OP_IMM) begin
      uop = issue_pkg::UOP_ADDI;
    end else if (opcode == issue_pkg::OPC_OP && funct7 == issue_pkg::FUNCT7_MUL) begin
      uop = issue_pkg::UOP_MUL;
    end else begin
      uop = issue_pkg::UOP_ADD;
    end
  end

  assign uses_rs2 = (uop != issue_pkg::UOP_ADDI);
  // x0 destination writes nothing
  assign rd_wen   = (rd != '0);

  // --------------------------------------------------------------------------
  // Register file and scoreboard
  // --------------------------------------------------------------------------

  issue_pkg::word_t    regs [32];
  logic [31:0]         sb;
  issue_pkg::seq_num_t seq_cnt;
  logic                hazard;

  // Completion writes at the edge, readers see it the cycle after
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (complete_val && complete_wen && complete_waddr != '0) begin
      regs[complete_waddr] <= complete_wdata;
    end
  end

  // RAW on rs1/rs2, WAW on rd
  assign hazard = sb[rs1] || (uses_rs2 && sb[rs2]) || (rd_wen && sb[rd]);

  // Clear from completion, set from issue; never the same bit in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      sb      <= '0;
      seq_cnt <= '0;
    end else begin
      if (complete_val && complete_wen) begin
        sb[complete_waddr] <= 1'b0;
      end
      if (issue_fire) begin
        seq_cnt <= seq_cnt + 1'b1;
        if (rd_wen) begin
          sb[rd] <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Steering
  // --------------------------------------------------------------------------

  // val does not look at rdy; once raised it stays until taken
  assign alu_val    = d_val && !hazard && (uop != issue_pkg::UOP_MUL);
  assign mul_val    = d_val && !hazard && (uop == issue_pkg::UOP_MUL);
  assign issue_fire = (alu_val && alu_rdy) || (mul_val && mul_rdy);

  assign iss_op1   = regs[rs1];
  assign iss_op2   = uses_rs2 ? regs[rs2] : imm_i;
  assign iss_waddr = rd;
  assign iss_wen   = rd_wen;
  assign iss_seq   = seq_cnt;
  assign iss_uop   = uop;

endmodule

/* issue_pkg.sv */
// Shared widths, RV32 encoding fields and micro-op codes for the
// decode/issue stage and its two execute pipes.
// Every RTL file refers to these by scoped name.
package issue_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Sequence tag width, wraps modulo 32
  localparam int SEQ_BITS = 5;

  // Data and instruction word
  typedef logic [31:0]          word_t;
  // Architectural register index
  typedef logic [4:0]           reg_addr_t;
  typedef logic [SEQ_BITS-1:0]  seq_num_t;
  // Micro-op sent down with every issued instruction
  typedef logic [1:0]           uop_t;

  // --------------------------------------------------------------------------
  // Execute pipes
  // --------------------------------------------------------------------------

  localparam int NUM_PIPES  = 2;
  // Depth of the multiply pipe
  localparam int MUL_STAGES = 3;

  // Bit positions in req and gnt
  localparam int PIPE_ALU = 0;
  localparam int PIPE_MUL = 1;

  // --------------------------------------------------------------------------
  // Micro-ops and RV32 encodings
  // --------------------------------------------------------------------------

  localparam uop_t UOP_ADD  = 2'd0;
  localparam uop_t UOP_ADDI = 2'd1;
  localparam uop_t UOP_MUL  = 2'd2;

  // Register-register and register-immediate ALU opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // M extension marker in funct7
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

endpackage
